// File: logic/mesh_pkg.sv
// mesh packet definitions
// coordinate, address and data word types shared by the master, the endpoint
// and the memory tile, plus the request opcode and master FSM encodings

package mesh_pkg;

    ////////////////////////////////
    // field widths
    ////////////////////////////////

    localparam int x_cord_width_c = 4;
    localparam int y_cord_width_c = 4;
    localparam int addr_width_c   = 8;
    localparam int data_width_c   = 32;

    // one memory word per remote address
    localparam int mem_words_c    = 1 << addr_width_c;

    ////////////////////////////////
    // packet fields
    ////////////////////////////////

    // mesh coordinates
    typedef logic [x_cord_width_c-1:0] x_cord_t;
    typedef logic [y_cord_width_c-1:0] y_cord_t;

    // remote word address
    typedef logic [addr_width_c-1:0]   addr_t;

    // payload and load return word
    typedef logic [data_width_c-1:0]   data_t;

    // remote access opcode
    typedef enum logic {
        op_store = 1'b0,
        op_load  = 1'b1
    } packet_op_e;

    ////////////////////////////////
    // traffic master FSM
    ////////////////////////////////

    // writing and reading issue requests, waiting only collects returns
    typedef enum logic [1:0] {
        st_writing = 2'b00,
        st_reading = 2'b01,
        st_waiting = 2'b10,
        st_finish  = 2'b11
    } master_state_e;

endpackage

// File: logic/traffic_master.sv
// traffic master
// writes a counting sequence to a remote tile with stores, reads it back with
// loads and checks every returned word in order, then raises finish

`timescale 1ns/1ps

module traffic_master
    import mesh_pkg::*;
#(
    parameter int seq_len_p = 32
) (
    input  logic       clk_i,
    input  logic       reset_i,

    input  x_cord_t    my_x_i,
    input  y_cord_t    my_y_i,
    input  x_cord_t    dest_x_i,
    input  y_cord_t    dest_y_i,

    // request toward the endpoint
    output logic       out_v_o,
    output packet_op_e out_op_o,
    output addr_t      out_addr_o,
    output data_t      out_data_o,
    output x_cord_t    out_src_x_o,
    output y_cord_t    out_src_y_o,
    output x_cord_t    out_dest_x_o,
    output y_cord_t    out_dest_y_o,
    input  logic       out_ready_i,

    // load returns, always accepted
    input  logic       returned_v_i,
    input  data_t      returned_data_i,

    output logic       finish_o,
    output logic [7:0] mismatch_count_o
);

    localparam addr_t last_addr_lp     = addr_t'(seq_len_p - 1);
    localparam int    ret_cnt_width_lp = $clog2(seq_len_p + 1);

    master_state_e               state_r;
    master_state_e               state_n;
    logic                        started_r;
    addr_t                       addr_r;
    logic [ret_cnt_width_lp-1:0] ret_cnt_r;
    logic [7:0]                  mismatch_r;

    logic launch;
    logic addr_last;
    logic ret_last;
    logic ret_mismatch;

    ////////////////////////////////
    // state machine
    ////////////////////////////////

    assign addr_last = (addr_r == last_addr_lp);
    assign launch    = out_v_o && out_ready_i;
    assign ret_last  = returned_v_i && (ret_cnt_r == ret_cnt_width_lp'(seq_len_p - 1));

    always_comb begin
        state_n = state_r;
        case (state_r)
            st_writing: begin
                if (launch && addr_last) begin
                    state_n = st_reading;
                end
            end
            st_reading: begin
                if (launch && addr_last) begin
                    state_n = st_waiting;
                end
            end
            st_waiting: begin
                if (ret_last) begin
                    state_n = st_finish;
                end
            end
            default: begin
                state_n = st_finish;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r   <= st_writing;
            started_r <= 1'b0;
        end else begin
            state_r   <= state_n;
            // one idle cycle after reset before the first request
            started_r <= 1'b1;
        end
    end

    assign finish_o = (state_r == st_finish);

    ////////////////////////////////
    // request generation
    ////////////////////////////////

    // address wraps to zero between the store and the load pass
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            addr_r <= '0;
        end else if (launch) begin
            addr_r <= addr_last ? '0 : addr_r + 1'b1;
        end
    end

    assign out_v_o      = started_r && ((state_r == st_writing) || (state_r == st_reading));
    assign out_op_o     = (state_r == st_writing) ? op_store : op_load;
    assign out_addr_o   = addr_r;
    // stored word equals its address
    assign out_data_o   = data_t'(addr_r);
    assign out_src_x_o  = my_x_i;
    assign out_src_y_o  = my_y_i;
    assign out_dest_x_o = dest_x_i;
    assign out_dest_y_o = dest_y_i;

    ////////////////////////////////
    // return checker
    ////////////////////////////////

    // k-th return must carry the value k
    assign ret_mismatch = returned_v_i && (returned_data_i != data_t'(ret_cnt_r));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ret_cnt_r  <= '0;
            mismatch_r <= '0;
        end else if (state_r != st_finish) begin
            if (returned_v_i) begin
                ret_cnt_r <= ret_cnt_r + 1'b1;
            end
            if (ret_mismatch && (mismatch_r != 8'hff)) begin
                mismatch_r <= mismatch_r + 1'b1;
            end
        end
    end

    assign mismatch_count_o = mismatch_r;

endmodule

// File: logic/mesh_endpoint.sv
// mesh endpoint
// buffers outgoing requests in a small FIFO, limits outstanding requests
// with a credit counter and registers load data on the way back

`timescale 1ns/1ps

module mesh_endpoint
    import mesh_pkg::*;
#(
    parameter int fifo_els_p        = 4,
    parameter int max_out_credits_p = 16
) (
    input  logic       clk_i,
    input  logic       reset_i,

    // request from the master
    input  logic       out_v_i,
    input  packet_op_e out_op_i,
    input  addr_t      out_addr_i,
    input  data_t      out_data_i,
    input  x_cord_t    out_src_x_i,
    input  y_cord_t    out_src_y_i,
    input  x_cord_t    out_dest_x_i,
    input  y_cord_t    out_dest_y_i,
    output logic       out_ready_o,

    // FIFO head toward the tile
    output logic       req_v_o,
    output packet_op_e req_op_o,
    output addr_t      req_addr_o,
    output data_t      req_data_o,
    output x_cord_t    req_dest_x_o,
    output y_cord_t    req_dest_y_o,
    input  logic       req_take_i,

    // responses from the tile
    input  logic       rsp_v_i,
    input  logic       rsp_is_load_i,
    input  data_t      rsp_data_i,

    output logic       returned_v_o,
    output data_t      returned_data_o
);

    localparam int ptr_width_lp    = (fifo_els_p > 1) ? $clog2(fifo_els_p) : 1;
    localparam int cnt_width_lp    = $clog2(fifo_els_p + 1);
    localparam int credit_width_lp = $clog2(max_out_credits_p + 1);
    localparam int src_width_lp    = $bits(x_cord_t) + $bits(y_cord_t);
    localparam int entry_width_lp  = 1 + $bits(addr_t) + $bits(data_t) + 2 * src_width_lp;

    typedef logic [entry_width_lp-1:0] entry_t;

    entry_t                     fifo_mem [fifo_els_p];
    entry_t                     fifo_head;
    logic [ptr_width_lp-1:0]    wr_ptr_r;
    logic [ptr_width_lp-1:0]    rd_ptr_r;
    logic [cnt_width_lp-1:0]    fifo_cnt_r;
    logic [credit_width_lp-1:0] credit_cnt_r;
    logic                       rsp_v_r;
    logic                       returned_v_r;
    data_t                      returned_data_r;

    logic fifo_full;
    logic fifo_push;
    logic fifo_pop;

    ////////////////////////////////
    // request FIFO
    ////////////////////////////////

    assign fifo_full   = (fifo_cnt_r == cnt_width_lp'(fifo_els_p));
    assign out_ready_o = !fifo_full && (credit_cnt_r < credit_width_lp'(max_out_credits_p));
    assign fifo_push   = out_v_i && out_ready_o;
    assign fifo_pop    = req_take_i && req_v_o;

    // source coordinates travel in the low bits of each entry
    always_ff @(posedge clk_i) begin
        if (fifo_push) begin
            fifo_mem[wr_ptr_r] <= {out_op_i, out_addr_i, out_data_i, out_dest_x_i,
                                   out_dest_y_i, out_src_x_i, out_src_y_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r   <= '0;
            rd_ptr_r   <= '0;
            fifo_cnt_r <= '0;
        end else begin
            if (fifo_push) begin
                wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(fifo_els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(fifo_els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            if (fifo_push && !fifo_pop) begin
                fifo_cnt_r <= fifo_cnt_r + 1'b1;
            end else if (!fifo_push && fifo_pop) begin
                fifo_cnt_r <= fifo_cnt_r - 1'b1;
            end
        end
    end

    assign fifo_head = fifo_mem[rd_ptr_r];
    assign req_v_o   = (fifo_cnt_r != '0);
    assign req_op_o  = packet_op_e'(fifo_head[entry_width_lp-1]);
    assign {req_addr_o, req_data_o, req_dest_x_o, req_dest_y_o} =
        fifo_head[entry_width_lp-2:src_width_lp];

    ////////////////////////////////
    // credits and return path
    ////////////////////////////////

    // a credit comes back in the same cycle the registered response appears
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            credit_cnt_r <= '0;
            rsp_v_r      <= 1'b0;
            returned_v_r <= 1'b0;
        end else begin
            rsp_v_r      <= rsp_v_i;
            returned_v_r <= rsp_v_i && rsp_is_load_i;
            if (fifo_push && !rsp_v_r) begin
                credit_cnt_r <= credit_cnt_r + 1'b1;
            end else if (!fifo_push && rsp_v_r) begin
                credit_cnt_r <= credit_cnt_r - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_v_i && rsp_is_load_i) begin
            returned_data_r <= rsp_data_i;
        end
    end

    assign returned_v_o    = returned_v_r;
    assign returned_data_o = returned_data_r;

endmodule

// File: logic/mem_tile.sv
// memory tile
// remote target that executes stores and loads addressed to its own mesh
// coordinates and answers each one a cycle later

`timescale 1ns/1ps

module mem_tile
    import mesh_pkg::*;
#(
    parameter x_cord_t tile_x_p = 1,
    parameter y_cord_t tile_y_p = 2
) (
    input  logic       clk_i,
    input  logic       reset_i,

    // network back-pressure
    input  logic       net_stall_i,

    // request head from the endpoint
    input  logic       req_v_i,
    input  packet_op_e req_op_i,
    input  addr_t      req_addr_i,
    input  data_t      req_data_i,
    input  x_cord_t    req_dest_x_i,
    input  y_cord_t    req_dest_y_i,
    output logic       req_take_o,

    // response toward the endpoint
    output logic       rsp_v_o,
    output logic       rsp_is_load_o,
    output data_t      rsp_data_o
);

    data_t mem [mem_words_c];

    logic  rsp_v_r;
    logic  rsp_is_load_r;
    data_t rsp_data_r;

    logic  take;
    logic  hit;
    logic  do_store;
    logic  do_load;

    ////////////////////////////////
    // request decode
    ////////////////////////////////

    // the head is consumed whenever the network is not stalled
    assign take = req_v_i && !net_stall_i;

    // only packets for this tile have any effect
    assign hit = (req_dest_x_i == tile_x_p) && (req_dest_y_i == tile_y_p);

    assign do_store = take && hit && (req_op_i == op_store);
    assign do_load  = take && hit && (req_op_i == op_load);

    assign req_take_o = take;

    ////////////////////////////////
    // storage
    ////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (do_store) begin
            mem[req_addr_i] <= req_data_i;
        end
    end

    ////////////////////////////////
    // response
    ////////////////////////////////

    // one pulse per matching request, misrouted packets get nothing
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_v_r <= 1'b0;
        end else begin
            rsp_v_r <= take && hit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take && hit) begin
            rsp_is_load_r <= (req_op_i == op_load);
        end
        if (do_load) begin
            rsp_data_r <= mem[req_addr_i];
        end
    end

    assign rsp_v_o       = rsp_v_r;
    assign rsp_is_load_o = rsp_is_load_r;
    assign rsp_data_o    = rsp_data_r;

endmodule

// File: logic/mesh_master_top.sv
// single-node mesh traffic test
// traffic master, endpoint and memory tile wired together

`timescale 1ns/1ps

module mesh_master_top
    import mesh_pkg::*;
#(
    parameter int      seq_len_p         = 32,
    parameter int      fifo_els_p        = 4,
    parameter int      max_out_credits_p = 16,
    parameter x_cord_t tile_x_p          = 1,
    parameter y_cord_t tile_y_p          = 2
) (
    input  logic       clk_i,
    input  logic       reset_i,
    input  x_cord_t    my_x_i,
    input  y_cord_t    my_y_i,
    input  x_cord_t    dest_x_i,
    input  y_cord_t    dest_y_i,
    input  logic       net_stall_i,
    output logic       finish_o,
    output logic       returned_v_o,
    output data_t      returned_data_o,
    output logic [7:0] mismatch_count_o
);

    ////////////////////////////////
    // master to endpoint
    ////////////////////////////////

    logic       out_v;
    packet_op_e out_op;
    addr_t      out_addr;
    data_t      out_data;
    x_cord_t    out_src_x;
    y_cord_t    out_src_y;
    x_cord_t    out_dest_x;
    y_cord_t    out_dest_y;
    logic       out_ready;

    ////////////////////////////////
    // endpoint to tile
    ////////////////////////////////

    logic       req_v;
    packet_op_e req_op;
    addr_t      req_addr;
    data_t      req_data;
    x_cord_t    req_dest_x;
    y_cord_t    req_dest_y;
    logic       req_take;
    logic       rsp_v;
    logic       rsp_is_load;
    data_t      rsp_data;

    traffic_master #(
        .seq_len_p (seq_len_p)
    ) i_traffic_master (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .my_x_i           (my_x_i),
        .my_y_i           (my_y_i),
        .dest_x_i         (dest_x_i),
        .dest_y_i         (dest_y_i),
        .out_v_o          (out_v),
        .out_op_o         (out_op),
        .out_addr_o       (out_addr),
        .out_data_o       (out_data),
        .out_src_x_o      (out_src_x),
        .out_src_y_o      (out_src_y),
        .out_dest_x_o     (out_dest_x),
        .out_dest_y_o     (out_dest_y),
        .out_ready_i      (out_ready),
        .returned_v_i     (returned_v_o),
        .returned_data_i  (returned_data_o),
        .finish_o         (finish_o),
        .mismatch_count_o (mismatch_count_o)
    );

    mesh_endpoint #(
        .fifo_els_p        (fifo_els_p),
        .max_out_credits_p (max_out_credits_p)
    ) i_mesh_endpoint (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .out_v_i         (out_v),
        .out_op_i        (out_op),
        .out_addr_i      (out_addr),
        .out_data_i      (out_data),
        .out_src_x_i     (out_src_x),
        .out_src_y_i     (out_src_y),
        .out_dest_x_i    (out_dest_x),
        .out_dest_y_i    (out_dest_y),
        .out_ready_o     (out_ready),
        .req_v_o         (req_v),
        .req_op_o        (req_op),
        .req_addr_o      (req_addr),
        .req_data_o      (req_data),
        .req_dest_x_o    (req_dest_x),
        .req_dest_y_o    (req_dest_y),
        .req_take_i      (req_take),
        .rsp_v_i         (rsp_v),
        .rsp_is_load_i   (rsp_is_load),
        .rsp_data_i      (rsp_data),
        .returned_v_o    (returned_v_o),
        .returned_data_o (returned_data_o)
    );

    mem_tile #(
        .tile_x_p (tile_x_p),
        .tile_y_p (tile_y_p)
    ) i_mem_tile (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .net_stall_i   (net_stall_i),
        .req_v_i       (req_v),
        .req_op_i      (req_op),
        .req_addr_i    (req_addr),
        .req_data_i    (req_data),
        .req_dest_x_i  (req_dest_x),
        .req_dest_y_i  (req_dest_y),
        .req_take_o    (req_take),
        .rsp_v_o       (rsp_v),
        .rsp_is_load_o (rsp_is_load),
        .rsp_data_o    (rsp_data)
    );

endmodule

// File: verification/mesh_master_assert.sv
// endpoint checks
// credit bound, FIFO fill count within its depth, returns only with credits out

`timescale 1ns/1ps

module mesh_master_assert #(
    parameter int fifo_els_p        = 4,
    parameter int max_out_credits_p = 16
) (
    input logic                                   clk_i,
    input logic                                   reset_i,
    input logic [$clog2(max_out_credits_p+1)-1:0] credit_cnt_i,
    input logic [$clog2(fifo_els_p+1)-1:0]        fifo_cnt_i,
    input logic                                   returned_v_i
);

    credit_bound_a: assert property (@(posedge clk_i) disable iff (reset_i)
        credit_cnt_i <= max_out_credits_p)
        else $error("credit count %0d above %0d", credit_cnt_i, max_out_credits_p);

    // a push into a full FIFO would carry the fill count past the depth
    no_push_full_a: assert property (@(posedge clk_i) disable iff (reset_i)
        fifo_cnt_i <= fifo_els_p)
        else $error("push into a full request FIFO, fill count %0d", fifo_cnt_i);

    return_credit_a: assert property (@(posedge clk_i) disable iff (reset_i)
        returned_v_i |-> (credit_cnt_i != 0))
        else $error("load return with no request outstanding");

endmodule

bind mesh_endpoint mesh_master_assert #(
    .fifo_els_p        (fifo_els_p),
    .max_out_credits_p (max_out_credits_p)
) i_mesh_master_assert (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .credit_cnt_i (credit_cnt_r),
    .fifo_cnt_i   (fifo_cnt_r),
    .returned_v_i (returned_v_o)
);

// File: verification/mesh_master_tb.sv
// testbench for the single-node mesh traffic test
// directed tests with a model of the store pass, LFSR stall patterns
// and a summary of the results

`timescale 1ns/1ps

module mesh_master_tb;
    import mesh_pkg::*;

    localparam int      seq_len_c = 32;
    localparam x_cord_t tile_x_c  = 1;
    localparam y_cord_t tile_y_c  = 2;
    localparam int      run_tmo_c = 3000;

    logic       clk_i;
    logic       reset_i;
    x_cord_t    my_x_i;
    y_cord_t    my_y_i;
    x_cord_t    dest_x_i;
    y_cord_t    dest_y_i;
    logic       net_stall_i;
    logic       finish_o;
    logic       returned_v_o;
    data_t      returned_data_o;
    logic [7:0] mismatch_count_o;

    data_t       model_mem [seq_len_c];
    logic [31:0] lfsr_r;
    logic        random_stall;
    int          ret_seen;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    mesh_master_top #(
        .seq_len_p (seq_len_c)
    ) i_mesh_master_top (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .my_x_i           (my_x_i),
        .my_y_i           (my_y_i),
        .dest_x_i         (dest_x_i),
        .dest_y_i         (dest_y_i),
        .net_stall_i      (net_stall_i),
        .finish_o         (finish_o),
        .returned_v_o     (returned_v_o),
        .returned_data_o  (returned_data_o),
        .mismatch_count_o (mismatch_count_o)
    );

    always #20 clk_i = ~clk_i;

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // right-shifting Galois LFSR
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] nxt;
        nxt = state >> 1;
        if (state[0]) begin
            nxt = nxt ^ 32'ha3000000;
        end
        return nxt;
    endfunction

    // store pass writes every address with its own value, loads come back in order
    task automatic build_model();
        for (int a = 0; a < seq_len_c; a++) begin
            model_mem[a] = data_t'(a);
        end
    endtask

    task automatic drive_cycle();
        @(posedge clk_i);
        #2;
        if (random_stall) begin
            lfsr_r      = lfsr_step(lfsr_r);
            net_stall_i = lfsr_r[0];
        end
    endtask

    task automatic apply_reset(input x_cord_t dest_x, input logic stall, input logic use_lfsr);
        @(posedge clk_i);
        #2;
        reset_i      = 1'b1;
        dest_x_i     = dest_x;
        dest_y_i     = tile_y_c;
        net_stall_i  = stall;
        random_stall = use_lfsr;
        repeat (3) begin
            @(posedge clk_i);
        end
        #2;
        reset_i  = 1'b0;
        ret_seen = 0;
    endtask

    //////////////////////////////
    // return monitor
    //////////////////////////////

    always @(negedge clk_i) begin
        if (!reset_i && returned_v_o) begin
            if (ret_seen >= seq_len_c) begin
                $display("error at %0d ns: return %0d beyond the sequence", $time, ret_seen);
                error_count++;
            end else if (returned_data_o !== model_mem[ret_seen]) begin
                $display("error at %0d ns: return %0d carried %0h, expected %0h",
                         $time, ret_seen, returned_data_o, model_mem[ret_seen]);
                error_count++;
            end
            ret_seen++;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic wait_finish(input int max_cycles, input string name);
        int cycles;
        cycles = 0;
        while (!finish_o && cycles < max_cycles) begin
            drive_cycle();
            @(negedge clk_i);
            cycles++;
        end
        if (!finish_o) begin
            $display("%s: finish_o did not rise within %0d cycles", name, max_cycles);
            error_count++;
        end
    endtask

    // a few trailing cycles catch late or extra returns
    task automatic check_run(input string name);
        repeat (10) begin
            drive_cycle();
        end
        if (ret_seen != seq_len_c) begin
            $display("error at %0d ns: %s saw %0d returns, expected %0d",
                     $time, name, ret_seen, seq_len_c);
            error_count++;
        end
        if (mismatch_count_o != 8'd0) begin
            $display("error at %0d ns: %s mismatch count %0d, expected 0",
                     $time, name, mismatch_count_o);
            error_count++;
        end
        if (!finish_o) begin
            $display("%s: finish_o dropped without a reset", name);
            error_count++;
        end
    endtask

    task automatic expect_quiet(input int cycles, input string name);
        logic early_finish;
        early_finish = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            drive_cycle();
            @(negedge clk_i);
            if (finish_o && !early_finish) begin
                $display("error at %0d ns: %s raised finish_o", $time, name);
                error_count++;
                early_finish = 1'b1;
            end
        end
        if (ret_seen != 0) begin
            $display("error at %0d ns: %s saw %0d returns, expected none", $time, name, ret_seen);
            error_count++;
        end
    endtask

    task automatic check_idle(input string name);
        @(negedge clk_i);
        if (finish_o || returned_v_o) begin
            $display("error at %0d ns: %s finish_o %b returned_v_o %b after reset, expected 0 0",
                     $time, name, finish_o, returned_v_o);
            error_count++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
            tests_failed++;
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic test_basic_run();
        int errs;
        errs = error_count;
        apply_reset(tile_x_c, 1'b0, 1'b0);
        wait_finish(run_tmo_c, "basic run");
        check_run("basic run");
        end_test("basic run", errs);
    endtask

    task automatic test_random_stalls();
        int errs;
        errs = error_count;
        apply_reset(tile_x_c, 1'b0, 1'b1);
        wait_finish(run_tmo_c, "random stalls");
        check_run("random stalls");
        end_test("random stalls", errs);
    endtask

    task automatic test_long_stall();
        int errs;
        errs = error_count;
        apply_reset(tile_x_c, 1'b1, 1'b0);
        expect_quiet(100, "long stall");
        @(posedge clk_i);
        #2;
        net_stall_i = 1'b0;
        wait_finish(run_tmo_c, "long stall");
        check_run("long stall");
        end_test("long stall", errs);
    endtask

    // dropped packets never return their credits
    task automatic test_wrong_dest();
        int errs;
        errs = error_count;
        apply_reset(tile_x_c + 1'b1, 1'b0, 1'b0);
        expect_quiet(500, "wrong destination");
        end_test("wrong destination", errs);
    endtask

    task automatic test_reset_behavior();
        int errs;
        errs = error_count;
        apply_reset(tile_x_c, 1'b0, 1'b0);
        check_idle("reset");
        wait_finish(run_tmo_c, "reset first run");
        check_run("reset first run");
        apply_reset(tile_x_c, 1'b0, 1'b0);
        check_idle("reset after finish");
        wait_finish(run_tmo_c, "reset second run");
        check_run("reset second run");
        end_test("reset behavior", errs);
    endtask

    initial begin
        clk_i        = 1'b0;
        reset_i      = 1'b1;
        my_x_i       = '0;
        my_y_i       = '0;
        dest_x_i     = tile_x_c;
        dest_y_i     = tile_y_c;
        net_stall_i  = 1'b0;
        random_stall = 1'b0;
        lfsr_r       = 32'h4f5fe943;
        ret_seen     = 0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        build_model();

        test_basic_run();
        test_random_stalls();
        test_long_stall();
        test_wrong_dest();
        test_reset_behavior();

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/mesh_pkg.sv
logic/traffic_master.sv
logic/mesh_endpoint.sv
logic/mem_tile.sv
logic/mesh_master_top.sv
verification/mesh_master_assert.sv
verification/mesh_master_tb.sv

// File: Makefile
# Verilator build and run of the mesh traffic testbench

TOP = mesh_master_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
